// File: rtl/cache_pkg.sv
package cache_pkg;

   // byte address and word sizes shared by the front end and the back end
   localparam int ADDR_W      = 16;
   localparam int DATA_W      = 32;

   // address fields from the least significant bit upwards
   localparam int BYTE_OFF_W  = 2;
   localparam int WORD_OFF_W  = 2;
   localparam int INDEX_W     = 4;
   localparam int TAG_W       = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

   localparam int LINE_WORDS  = 1 << WORD_OFF_W;  // words held by one line
   localparam int LINES       = 1 << INDEX_W;
   localparam int LINE_ADDR_W = TAG_W + INDEX_W;  // tag and index without the offsets

   // bit positions of the index and tag fields
   localparam int INDEX_LSB   = BYTE_OFF_W + WORD_OFF_W;
   localparam int TAG_LSB     = INDEX_LSB + INDEX_W;

endpackage

// File: rtl/line_refill.sv
`timescale 1ns/1ns

module line_refill import cache_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   replace_valid,
   input  logic [LINE_ADDR_W-1:0] replace_addr,
   output logic                   replace,
   output logic                   read_valid,
   output logic [WORD_OFF_W-1:0]  read_addr,
   output logic [DATA_W-1:0]      read_rdata,
   output logic [ADDR_W-1:0]      be_addr,
   output logic                   be_valid,
   input  logic                   be_ready,
   input  logic [DATA_W-1:0]      be_rdata
);

   typedef enum logic [1:0] {
      IDLE,
      HANDSHAKE,
      END_HANDSHAKE
   } state_t;

   state_t                  state;
   logic [WORD_OFF_W-1:0]   word_counter;
   logic                    last_word;

   assign last_word = &word_counter;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state        <= IDLE;
         word_counter <= '0;
      end else begin
         case (state)
            IDLE: begin
               word_counter <= '0;
               if (replace_valid) begin
                  state <= HANDSHAKE;
               end
            end
            HANDSHAKE: begin
               if (be_ready) begin
                  word_counter <= word_counter + 1'b1;  // wraps back to zero after the last word
                  if (last_word) begin
                     state <= END_HANDSHAKE;
                  end
               end
            end
            END_HANDSHAKE: begin
               state <= IDLE;  // one cycle so the last word lands before the reread
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // the address only moves on an accepted beat, so it holds under back-pressure
   assign be_addr    = {replace_addr, word_counter, {BYTE_OFF_W{1'b0}}};
   assign be_valid   = (state == HANDSHAKE);
   assign replace    = (state != IDLE);

   // returned words go straight to the data store write port
   assign read_valid = (state == HANDSHAKE) && be_ready;
   assign read_addr  = word_counter;
   assign read_rdata = be_rdata;

endmodule

// File: rtl/tag_store.sv
`timescale 1ns/1ns

module tag_store import cache_pkg::*; (
   input  logic               clk,
   input  logic               reset,
   input  logic               tag_we,
   input  logic [INDEX_W-1:0] tag_index,
   input  logic [TAG_W-1:0]   tag_wdata,
   output logic [TAG_W-1:0]   hit_tag,
   output logic               hit_valid
);

   logic [TAG_W-1:0]  tags [LINES];
   logic [LINES-1:0]  valid;

   always_ff @(posedge clk) begin
      if (tag_we) begin
         tags[tag_index] <= tag_wdata;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         valid <= '0;  // every line starts empty
      end else if (tag_we) begin
         valid[tag_index] <= 1'b1;
      end
   end

   // lookup is combinational so the compare fits in the lookup cycle
   assign hit_tag   = tags[tag_index];
   assign hit_valid = valid[tag_index];

endmodule

// File: rtl/data_store.sv
`timescale 1ns/1ns

module data_store import cache_pkg::*; (
   input  logic                  clk,
   input  logic                  we,
   input  logic [INDEX_W-1:0]    windex,
   input  logic [WORD_OFF_W-1:0] woffset,
   input  logic [DATA_W-1:0]     wdata,
   input  logic [INDEX_W-1:0]    rindex,
   input  logic [WORD_OFF_W-1:0] roffset,
   output logic [DATA_W-1:0]     rdata
);

   logic [DATA_W-1:0]  mem [LINES * LINE_WORDS];

   // one word write port fed by the refill engine
   always_ff @(posedge clk) begin
      if (we) begin
         mem[{windex, woffset}] <= wdata;
      end
   end

   // the read is registered every cycle, which maps onto a block RAM output register
   always_ff @(posedge clk) begin
      rdata <= mem[{rindex, roffset}];
   end

endmodule

// File: rtl/cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl import cache_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   req_valid,
   input  logic [ADDR_W-1:0]      req_addr,
   input  logic [TAG_W-1:0]       hit_tag,
   input  logic                   hit_valid,
   input  logic                   replace,
   input  logic [DATA_W-1:0]      rdata,
   output logic                   busy,
   output logic                   resp_valid,
   output logic [DATA_W-1:0]      resp_rdata,
   output logic                   tag_we,
   output logic [INDEX_W-1:0]     tag_index,
   output logic [TAG_W-1:0]       tag_wdata,
   output logic                   replace_valid,
   output logic [LINE_ADDR_W-1:0] replace_addr,
   output logic [INDEX_W-1:0]     rindex,
   output logic [WORD_OFF_W-1:0]  roffset,
   output logic [INDEX_W-1:0]     windex
);

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      REPLACE,
      WAIT_FILL,
      RESPOND
   } state_t;

   state_t             state;
   state_t             next_state;
   logic [ADDR_W-1:0]  addr_q;
   logic [ADDR_W-1:0]  raddr;
   logic               hit;
   logic               accept;

   assign hit        = hit_valid && (hit_tag == addr_q[ADDR_W-1:TAG_LSB]);
   assign resp_valid = ((state == LOOKUP) && hit) || (state == RESPOND);
   assign busy       = (state != IDLE) && !resp_valid;  // a new request may follow a response
   assign accept     = req_valid && !busy;
   assign resp_rdata = rdata;

   // the data store read starts in the request cycle so a hit answers one cycle later
   assign raddr   = accept ? req_addr : addr_q;
   assign rindex  = raddr[TAG_LSB-1:INDEX_LSB];
   assign roffset = raddr[INDEX_LSB-1:BYTE_OFF_W];

   assign windex        = addr_q[TAG_LSB-1:INDEX_LSB];
   assign tag_index     = windex;
   assign tag_wdata     = addr_q[ADDR_W-1:TAG_LSB];
   assign tag_we        = (state == LOOKUP) && !hit;  // claim the line as soon as the miss is known
   assign replace_valid = (state == REPLACE) && !replace;
   assign replace_addr  = addr_q[ADDR_W-1:INDEX_LSB];

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q <= req_addr;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (accept) begin
               next_state = LOOKUP;
            end
         end
         LOOKUP: begin
            if (!hit) begin
               next_state = REPLACE;
            end else if (!accept) begin
               next_state = IDLE;
            end
         end
         REPLACE: begin
            if (replace) begin
               next_state = WAIT_FILL;
            end
         end
         WAIT_FILL: begin
            if (!replace) begin
               next_state = RESPOND;  // the reread of the word is issued in this cycle
            end
         end
         RESPOND: begin
            next_state = accept ? LOOKUP : IDLE;
         end
         default: begin
            next_state = IDLE;
         end
      endcase
   end

endmodule

// File: rtl/read_cache.sv
`timescale 1ns/1ns

module read_cache import cache_pkg::*; (
   input  logic               clk,
   input  logic               reset,
   input  logic               req_valid,
   input  logic [ADDR_W-1:0]  req_addr,
   output logic               busy,
   output logic               resp_valid,
   output logic [DATA_W-1:0]  resp_rdata,
   output logic               be_valid,
   output logic [ADDR_W-1:0]  be_addr,
   input  logic               be_ready,
   input  logic [DATA_W-1:0]  be_rdata
);

   logic                    tag_we;
   logic [INDEX_W-1:0]      tag_index;
   logic [TAG_W-1:0]        tag_wdata;
   logic [TAG_W-1:0]        hit_tag;
   logic                    hit_valid;
   logic                    replace_valid;
   logic [LINE_ADDR_W-1:0]  replace_addr;
   logic                    replace;
   logic                    read_valid;
   logic [WORD_OFF_W-1:0]   read_addr;
   logic [DATA_W-1:0]       read_rdata;
   logic [INDEX_W-1:0]      rindex;
   logic [WORD_OFF_W-1:0]   roffset;
   logic [INDEX_W-1:0]      windex;
   logic [DATA_W-1:0]       rdata;

   cache_ctrl i_cache_ctrl (
      .clk           (clk),
      .reset         (reset),
      .req_valid     (req_valid),
      .req_addr      (req_addr),
      .hit_tag       (hit_tag),
      .hit_valid     (hit_valid),
      .replace       (replace),
      .rdata         (rdata),
      .busy          (busy),
      .resp_valid    (resp_valid),
      .resp_rdata    (resp_rdata),
      .tag_we        (tag_we),
      .tag_index     (tag_index),
      .tag_wdata     (tag_wdata),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .rindex        (rindex),
      .roffset       (roffset),
      .windex        (windex)
   );

   tag_store i_tag_store (
      .clk       (clk),
      .reset     (reset),
      .tag_we    (tag_we),
      .tag_index (tag_index),
      .tag_wdata (tag_wdata),
      .hit_tag   (hit_tag),
      .hit_valid (hit_valid)
   );

   // refill beats are written straight into the line picked by the controller
   data_store i_data_store (
      .clk     (clk),
      .we      (read_valid),
      .windex  (windex),
      .woffset (read_addr),
      .wdata   (read_rdata),
      .rindex  (rindex),
      .roffset (roffset),
      .rdata   (rdata)
   );

   line_refill i_line_refill (
      .clk           (clk),
      .reset         (reset),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace       (replace),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .be_addr       (be_addr),
      .be_valid      (be_valid),
      .be_ready      (be_ready),
      .be_rdata      (be_rdata)
   );

endmodule

// File: verification/mem_model.sv
`timescale 1ns/1ns

module mem_model import cache_pkg::*; (
   input  logic               clk,
   input  logic               reset,
   input  logic               stall,
   input  logic               be_valid,
   input  logic [ADDR_W-1:0]  be_addr,
   output logic               be_ready,
   output logic [DATA_W-1:0]  be_rdata
);

   logic  last_beat;

   // the refill engine drops be_valid right after the beat on the last word of a line
   assign last_beat = be_ready && (be_addr[INDEX_LSB-1:BYTE_OFF_W] == WORD_OFF_W'(LINE_WORDS - 1));

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         be_ready <= 1'b0;
      end else begin
         be_ready <= be_valid && !last_beat && !stall;
      end
   end

   assign be_rdata = {~be_addr, be_addr};  // inverted address above the address itself

endmodule

// File: verification/read_cache_assertions.sv
`timescale 1ns/1ns

module read_cache_assertions import cache_pkg::*; (
   input logic               clk,
   input logic               reset,
   input logic               req_valid,
   input logic [ADDR_W-1:0]  req_addr,
   input logic               busy,
   input logic               resp_valid,
   input logic [DATA_W-1:0]  resp_rdata,
   input logic               be_valid,
   input logic [ADDR_W-1:0]  be_addr,
   input logic               be_ready
);

   logic [ADDR_W-1:0]   last_addr;
   logic                in_flight;
   logic                pending_miss;
   logic [WORD_OFF_W:0] beats_seen;
   logic [TAG_W-1:0]    shadow_tag [LINES];
   logic [LINES-1:0]    shadow_valid;
   logic [INDEX_W-1:0]  req_index;
   logic                accept;
   logic                resident;
   logic [ADDR_W-1:0]   beat_addr;

   assign accept    = req_valid && !busy;
   assign req_index = req_addr[TAG_LSB-1:INDEX_LSB];
   assign resident  = shadow_valid[req_index] &&
                      shadow_tag[req_index] == req_addr[ADDR_W-1:TAG_LSB];
   assign beat_addr = {last_addr[ADDR_W-1:INDEX_LSB], beats_seen[WORD_OFF_W-1:0], 2'b00};

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         in_flight    <= 1'b0;
         beats_seen   <= '0;
         shadow_valid <= '0;
      end else begin
         in_flight <= accept || (in_flight && !resp_valid);
         if (accept) begin
            last_addr               <= req_addr;
            pending_miss            <= !resident;
            beats_seen              <= '0;
            shadow_valid[req_index] <= 1'b1;
            shadow_tag[req_index]   <= req_addr[ADDR_W-1:TAG_LSB];  // a miss evicts the old tag
         end else if (be_valid && be_ready) begin
            beats_seen <= beats_seen + 1'b1;
         end
      end
   end

   default disable iff (reset);

   assert property (@(posedge clk)
      shadow_valid == '0 |-> !busy && !resp_valid && !be_valid) else begin
      $error("busy, resp_valid or be_valid went high before the first request");
      read_cache_tb.error_count++;
   end

   assert property (@(posedge clk) resp_valid |-> resp_rdata == {~last_addr, last_addr}) else begin
      $error("FAILED resp_rdata: got %h, expected %h", $sampled(resp_rdata),
             $sampled({~last_addr, last_addr}));
      read_cache_tb.error_count++;
   end

   assert property (@(posedge clk) be_valid |-> be_addr == beat_addr) else begin
      $error("FAILED be_addr: got %h, expected %h", $sampled(be_addr), $sampled(beat_addr));
      read_cache_tb.error_count++;
   end

   assert property (@(posedge clk) be_valid && !be_ready |=> be_valid) else begin
      $error("be_valid dropped while a beat was still waiting for be_ready");
      read_cache_tb.error_count++;
   end

   assert property (@(posedge clk) accept && resident |=> resp_valid && !be_valid) else begin
      $error("a request to a resident line did not respond in the next cycle without a refill");
      read_cache_tb.error_count++;
   end

   assert property (@(posedge clk)
      resp_valid |-> in_flight && beats_seen == (pending_miss ? LINE_WORDS : 0)) else begin
      $error("response came without a request or after %0d refill beats", $sampled(beats_seen));
      read_cache_tb.error_count++;
   end

   assert property (@(posedge clk) in_flight && !resp_valid |-> busy) else begin
      $error("busy fell before the response to the pending request");
      read_cache_tb.error_count++;
   end

endmodule

// File: verification/read_cache_tb.sv
`timescale 1ns/1ns

module read_cache_tb import cache_pkg::*; ();

   localparam int DIRECTED_READS = 8;
   localparam int RANDOM_READS   = 200;
   localparam int CYCLE_LIMIT    = (DIRECTED_READS + RANDOM_READS) * 40;

   logic               clk = 1'b0;
   logic               reset;
   logic               req_valid;
   logic [ADDR_W-1:0]  req_addr;
   logic               busy;
   logic               resp_valid;
   logic [DATA_W-1:0]  resp_rdata;
   logic               be_valid;
   logic [ADDR_W-1:0]  be_addr;
   logic               be_ready;
   logic [DATA_W-1:0]  be_rdata;
   logic               stall;
   int                 error_count = 0;
   int                 cycle_count = 0;
   int                 reads_done = 0;

   always #4 clk = ~clk;

   read_cache i_dut (.*);

   mem_model i_mem_model (.*);

   bind read_cache read_cache_assertions i_assertions (.*);

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == CYCLE_LIMIT) begin
         $display("timeout: no response after %0d cycles, %0d reads done, %0d assertion failures",
                  cycle_count, reads_done, error_count);
         $display("Finished with errors");
         $finish;
      end
   end

   task automatic issue_read(input logic [ADDR_W-1:0] addr);
      @(negedge clk);
      while (busy) @(negedge clk);
      @(posedge clk);
      req_valid <= 1'b1;
      req_addr  <= addr;
      @(posedge clk);
      req_valid <= 1'b0;
      @(negedge clk);
      while (!resp_valid) @(negedge clk);
      reads_done++;
   endtask

   initial begin
      void'($urandom(32'hacb8_4421));
      reset     = 1'b1;
      req_valid = 1'b0;
      req_addr  = '0;
      stall     = 1'b0;
      fork
         forever begin
            @(posedge clk);
            stall <= ($urandom_range(3) == 0);  // about one back-end stall cycle in four
         end
      join_none
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      // fill line 0, hit it twice, evict it with tag 0x10 and miss on it again
      issue_read(16'h0000);
      issue_read(16'h0004);
      issue_read(16'h000c);
      issue_read(16'h1000);
      issue_read(16'h0008);
      issue_read(16'h0010);
      issue_read(16'h0018);
      issue_read(16'hfffc);
      // three tags over four lines give a steady mix of hits, misses and conflicts
      repeat (RANDOM_READS) begin
         issue_read({TAG_W'($urandom_range(2)), INDEX_W'($urandom_range(3)),
                     WORD_OFF_W'($urandom), 2'b00});
      end
      repeat (2) @(posedge clk);
      $display("%0d reads, %0d assertion failures", reads_done, error_count);
      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: src.f
rtl/cache_pkg.sv
rtl/line_refill.sv
rtl/tag_store.sv
rtl/data_store.sv
rtl/cache_ctrl.sv
rtl/read_cache.sv
verification/mem_model.sv
verification/read_cache_assertions.sv
verification/read_cache_tb.sv
